/* audioChannel.sv */
`timescale 1ns/1ns

module audioChannel (
    input  logic                                clk,
    input  logic                                i_rstN,
    input  logic                                i_regWr,
    input  audioPkg::regWrite_t                 i_reg,
    input  logic                                i_chanSel,
    input  logic                                i_load,
    input  logic signed [audioPkg::SAMPLE_W-1:0] i_sample,
    output audioPkg::chanState_t                o_state
);
    import audioPkg::*;

    logic [ADDR_W-1:0]          startAddr;
    logic [ADDR_W-1:0]          endAddr;
    logic [ADDR_W-1:0]          curAddr;
    logic [ADDR_W-1:0]          nextAddr;
    chanCtrl_t                  ctrl;
    logic                       playing;
    logic signed [SAMPLE_W-1:0] sample;
    logic                       wrEn;

    assign wrEn     = i_regWr && i_chanSel;
    assign nextAddr = curAddr + 1'b1;

    // Start and end only change by host write
    always_ff @(posedge clk) begin
        if (wrEn && i_reg.sel == REG_START) begin
            startAddr <= i_reg.data.addr;
        end
        if (wrEn && i_reg.sel == REG_END) begin
            endAddr <= i_reg.data.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            ctrl    <= '0;
            playing <= 1'b0;
            curAddr <= '0;
            sample  <= '0;
        end else begin
            if (i_load) begin
                sample <= i_sample;  // Zero when silent
                if (playing) begin
                    if (nextAddr == endAddr) begin
                        if (ctrl.loop) begin
                            curAddr <= startAddr;
                        end else begin
                            curAddr <= nextAddr;
                            playing <= 1'b0;
                        end
                    end else begin
                        curAddr <= nextAddr;
                    end
                end
            end
            // Host control write takes priority over a load
            if (wrEn && i_reg.sel == REG_CTRL) begin
                ctrl <= i_reg.data.ctrl;
                if (i_reg.data.ctrl.play) begin
                    playing <= 1'b1;
                    curAddr <= startAddr;
                end else begin
                    playing <= 1'b0;
                end
            end
        end
    end

    assign o_state.sample  = sample;
    assign o_state.addr    = curAddr;
    assign o_state.playing = playing;
    assign o_state.mono    = ctrl.mono;
    assign o_state.right   = ctrl.right;

endmodule

/* audioPkg.sv */
package audioPkg;

    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 24;

    // Register targeted by a host write
    typedef enum logic [1:0] {
        REG_START = 2'd0,  // First sample address
        REG_END   = 2'd1,  // Exclusive end address
        REG_CTRL  = 2'd2
    } regSel_e;

    typedef struct packed {
        logic [19:0] reserved;
        logic        loop;
        logic        mono;
        logic        right;  // Pan to right when not mono
        logic        play;
    } chanCtrl_t;

    // Same data word seen as an address or as a control word
    typedef union packed {
        logic [ADDR_W-1:0] addr;
        chanCtrl_t         ctrl;
    } regWord_u;

    typedef struct packed {
        logic [7:0] chanMask;  // One bit per channel
        regSel_e    sel;
        regWord_u   data;
    } regWrite_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] sample;
        logic [ADDR_W-1:0]          addr;
        logic                       playing;
        logic                       mono;
        logic                       right;
    } chanState_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } stereo_t;

endpackage

/* audioSystem.sv */
`timescale 1ns/1ns

module audioSystem #(
    parameter int NUM_CHANNELS = 8,
    parameter int CLK_DIV      = 4
) (
    input  logic                                 clk,
    input  logic                                 i_rstN,
    input  logic                                 i_regWr,
    input  audioPkg::regWrite_t                  i_reg,
    input  logic signed [audioPkg::SAMPLE_W-1:0] i_memData,
    output logic                                 o_memReq,
    output logic [audioPkg::ADDR_W-1:0]          o_memAddr,
    output logic [NUM_CHANNELS-1:0]              o_playing,
    output logic                                 o_bclk,
    output logic                                 o_lrclk,
    output logic                                 o_sdata
);
    import audioPkg::*;

    chanState_t [NUM_CHANNELS-1:0] chanState;
    logic [NUM_CHANNELS-1:0]       load;
    logic signed [SAMPLE_W-1:0]    loadSample;
    logic                          mixStrobe;
    logic                          frameStart;
    stereo_t                       mix;

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        audioChannel u_audioChannel (
            .clk       (clk),
            .i_rstN    (i_rstN),
            .i_regWr   (i_regWr),
            .i_reg     (i_reg),
            .i_chanSel (i_reg.chanMask[i]),
            .i_load    (load[i]),
            .i_sample  (loadSample),
            .o_state   (chanState[i])
        );
        assign o_playing[i] = chanState[i].playing;
    end

    sampleSequencer #(.NUM_CHANNELS(NUM_CHANNELS)) u_sampleSequencer (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_frameStart (frameStart),
        .i_chanState  (chanState),
        .i_memData    (i_memData),
        .o_memReq     (o_memReq),
        .o_memAddr    (o_memAddr),
        .o_load       (load),
        .o_loadSample (loadSample),
        .o_mixStrobe  (mixStrobe)
    );

    stereoMixer #(.NUM_CHANNELS(NUM_CHANNELS)) u_stereoMixer (
        .clk         (clk),
        .i_rstN      (i_rstN),
        .i_mixStrobe (mixStrobe),
        .i_chanState (chanState),
        .o_mix       (mix)
    );

    // Mix latched at frame start goes out during the next frame
    i2sTransmitter #(.CLK_DIV(CLK_DIV)) u_i2sTransmitter (
        .clk          (clk),
        .i_rstN       (i_rstN),
        .i_mix        (mix),
        .o_frameStart (frameStart),
        .o_bclk       (o_bclk),
        .o_lrclk      (o_lrclk),
        .o_sdata      (o_sdata)
    );

endmodule

/* i2sTransmitter.sv */
`timescale 1ns/1ns

module i2sTransmitter #(
    parameter int CLK_DIV = 4
) (
    input  logic              clk,
    input  logic              i_rstN,
    input  audioPkg::stereo_t i_mix,
    output logic              o_frameStart,
    output logic              o_bclk,
    output logic              o_lrclk,
    output logic              o_sdata
);
    import audioPkg::*;

    localparam int DIV_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int FRAME_W = 4 * SAMPLE_W;  // Two padded words

    logic [DIV_W-1:0]   divCnt;
    logic               halfTick;
    logic               fallTick;
    logic [5:0]         bitCnt;
    logic [FRAME_W-1:0] shReg;

    assign halfTick     = (divCnt == DIV_W'(CLK_DIV - 1));
    assign fallTick     = halfTick && o_bclk;
    assign o_frameStart = fallTick && (bitCnt == 6'd63);

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            divCnt <= '0;
            o_bclk <= 1'b0;
        end else if (halfTick) begin
            divCnt <= '0;
            o_bclk <= ~o_bclk;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Data and word select move on bit clock falling edges only
    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            bitCnt  <= '0;
            o_lrclk <= 1'b0;
            o_sdata <= 1'b0;
            shReg   <= '0;
        end else if (fallTick) begin
            bitCnt  <= bitCnt + 1'b1;
            o_lrclk <= (bitCnt + 1'b1) >= 6'd32;  // Low for left word
            if (o_frameStart) begin
                o_sdata <= i_mix.left[SAMPLE_W-1];
                shReg   <= {i_mix.left[SAMPLE_W-2:0], {SAMPLE_W{1'b0}},
                            i_mix.right, {SAMPLE_W{1'b0}}, 1'b0};
            end else begin
                o_sdata <= shReg[FRAME_W-1];
                shReg   <= {shReg[FRAME_W-2:0], 1'b0};
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the audio subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_audioSystem -f sources.f -o simAudio \
    && ./obj_dir/simAudio | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "Result: PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* sampleSequencer.sv */
`timescale 1ns/1ns

module sampleSequencer #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                                     clk,
    input  logic                                     i_rstN,
    input  logic                                     i_frameStart,
    input  audioPkg::chanState_t [NUM_CHANNELS-1:0]  i_chanState,
    input  logic signed [audioPkg::SAMPLE_W-1:0]     i_memData,
    output logic                                     o_memReq,
    output logic [audioPkg::ADDR_W-1:0]              o_memAddr,
    output logic [NUM_CHANNELS-1:0]                  o_load,
    output logic signed [audioPkg::SAMPLE_W-1:0]     o_loadSample,
    output logic                                     o_mixStrobe
);
    import audioPkg::*;

    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,  // Visit channel, request if playing
        ST_LOAD = 2'd2,  // Memory data valid
        ST_MIX  = 2'd3
    } seqState_e;

    seqState_e        state;
    seqState_e        stateNext;
    logic [IDX_W-1:0] chanIdx;
    logic             lastChan;
    logic             loadNow;
    chanState_t       visited;

    assign visited   = i_chanState[chanIdx];
    assign lastChan  = (chanIdx == IDX_W'(NUM_CHANNELS - 1));
    assign o_memAddr = visited.addr;

    always_comb begin
        stateNext    = state;
        o_memReq     = 1'b0;
        loadNow      = 1'b0;
        o_loadSample = '0;
        o_mixStrobe  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (i_frameStart) begin
                    stateNext = ST_REQ;
                end
            end
            ST_REQ: begin
                if (visited.playing) begin
                    o_memReq  = 1'b1;
                    stateNext = ST_LOAD;
                end else begin
                    loadNow   = 1'b1;  // Silent channel gets zero
                    stateNext = lastChan ? ST_MIX : ST_REQ;
                end
            end
            ST_LOAD: begin
                loadNow      = 1'b1;
                o_loadSample = i_memData;
                stateNext    = lastChan ? ST_MIX : ST_REQ;
            end
            ST_MIX: begin
                o_mixStrobe = 1'b1;
                stateNext   = ST_IDLE;
            end
            default: stateNext = ST_IDLE;
        endcase
    end

    always_comb begin
        o_load          = '0;
        o_load[chanIdx] = loadNow;
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            state   <= ST_IDLE;
            chanIdx <= '0;
        end else begin
            state <= stateNext;
            if (state == ST_IDLE) begin
                chanIdx <= '0;
            end else if (loadNow && !lastChan) begin
                chanIdx <= chanIdx + 1'b1;  // Next channel
            end
        end
    end

endmodule

/* sources.f */
audioPkg.sv
audioChannel.sv
sampleSequencer.sv
stereoMixer.sv
i2sTransmitter.sv
audioSystem.sv
tb_audioSystem_assert.sv
tb_audioSystem.sv

/* stereoMixer.sv */
`timescale 1ns/1ns

module stereoMixer #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                                    clk,
    input  logic                                    i_rstN,
    input  logic                                    i_mixStrobe,
    input  audioPkg::chanState_t [NUM_CHANNELS-1:0] i_chanState,
    output audioPkg::stereo_t                       o_mix
);
    import audioPkg::*;

    // Room for NUM_CHANNELS full-scale terms
    localparam int SUM_W = SAMPLE_W + $clog2(NUM_CHANNELS) + 1;
    localparam logic signed [SUM_W-1:0] MAX_VAL = SUM_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [SUM_W-1:0] MIN_VAL = SUM_W'(-(2 ** (SAMPLE_W - 1)));

    logic signed [SUM_W-1:0] leftSum;
    logic signed [SUM_W-1:0] rightSum;

    function automatic logic signed [SUM_W-1:0] extend(input logic signed [SAMPLE_W-1:0] s);
        return {{(SUM_W - SAMPLE_W){s[SAMPLE_W-1]}}, s};
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] saturate(input logic signed [SUM_W-1:0] v);
        if (v > MAX_VAL) begin
            return MAX_VAL[SAMPLE_W-1:0];
        end else if (v < MIN_VAL) begin
            return MIN_VAL[SAMPLE_W-1:0];
        end
        return v[SAMPLE_W-1:0];
    endfunction

    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (i_chanState[i].mono || !i_chanState[i].right) begin
                leftSum = leftSum + extend(i_chanState[i].sample);
            end
            if (i_chanState[i].mono || i_chanState[i].right) begin
                rightSum = rightSum + extend(i_chanState[i].sample);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            o_mix <= '0;
        end else if (i_mixStrobe) begin
            o_mix.left  <= saturate(leftSum);
            o_mix.right <= saturate(rightSum);
        end
    end

endmodule

/* tb_audioSystem.sv */
`timescale 1ns/1ns

module tb_audioSystem;
    import audioPkg::*;

    localparam int NUM_CH     = 8;
    localparam int CLK_DIV    = 4;
    localparam int WAIT_LIMIT = 256 * CLK_DIV + 32;  // Two frames plus slack

    logic                       clk;
    logic                       i_rstN;
    logic                       i_regWr;
    regWrite_t                  i_reg;
    logic signed [SAMPLE_W-1:0] i_memData;
    logic                       o_memReq;
    logic [ADDR_W-1:0]          o_memAddr;
    logic [NUM_CH-1:0]          o_playing;
    logic                       o_bclk;
    logic                       o_lrclk;
    logic                       o_sdata;

    logic signed [SAMPLE_W-1:0] sampleMem [1024];
    logic [31:0]                rngState = 32'd90732;
    logic                       reqSeen = 1'b0;
    logic [ADDR_W-1:0]          addrSeen = '0;

    stereo_t                    rxFrames [$];
    logic                       lastLr = 1'b0;
    int                         bitIdx = 0;
    logic [SAMPLE_W-1:0]        shiftWord = '0;
    logic [SAMPLE_W-1:0]        leftWord = '0;

    // Expected state of each voice
    chanCtrl_t                  swCtrl [NUM_CH];
    logic [9:0]                 swStart [NUM_CH];
    logic [9:0]                 swEnd [NUM_CH];
    logic [9:0]                 swAddr [NUM_CH];

    audioSystem #(.NUM_CHANNELS(NUM_CH), .CLK_DIV(CLK_DIV)) u_audioSystem (
        .clk       (clk),
        .i_rstN    (i_rstN),
        .i_regWr   (i_regWr),
        .i_reg     (i_reg),
        .i_memData (i_memData),
        .o_memReq  (o_memReq),
        .o_memAddr (o_memAddr),
        .o_playing (o_playing),
        .o_bclk    (o_bclk),
        .o_lrclk   (o_lrclk),
        .o_sdata   (o_sdata)
    );

    always #20 clk = ~clk;

    // Memory answers one cycle after the request
    always @(negedge clk) begin
        reqSeen  <= o_memReq;
        addrSeen <= o_memAddr;
    end

    always @(posedge clk) begin
        #5;
        if (reqSeen) begin
            i_memData = sampleMem[addrSeen[9:0]];
        end
    end

    always @(posedge o_bclk) begin
        if (o_lrclk != lastLr) begin
            bitIdx = 0;  // Word select moved
        end
        lastLr = o_lrclk;
        if (bitIdx < SAMPLE_W) begin
            shiftWord = {shiftWord[SAMPLE_W-2:0], o_sdata};
        end
        if (bitIdx == SAMPLE_W - 1) begin
            if (o_lrclk) begin
                rxFrames.push_back({leftWord, shiftWord});
            end else begin
                leftWord = shiftWord;
            end
        end
        bitIdx++;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] clampSample(input int v);
        if (v > 32767) begin
            return 16'sd32767;
        end else if (v < -32768) begin
            return -16'sd32768;
        end
        return 16'(v);
    endfunction

    // One frame of fetch and mix, straight from the channel rules
    function automatic stereo_t nextMixFrame();
        int      leftSum;
        int      rightSum;
        int      s;
        stereo_t f;
        leftSum  = 0;
        rightSum = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            s = 0;
            if (swCtrl[c].play) begin
                s         = sampleMem[swAddr[c]];
                swAddr[c] = swAddr[c] + 10'd1;
                if (swAddr[c] == swEnd[c]) begin
                    if (swCtrl[c].loop) begin
                        swAddr[c] = swStart[c];
                    end else begin
                        swCtrl[c].play = 1'b0;
                    end
                end
            end
            if (swCtrl[c].mono || !swCtrl[c].right) begin
                leftSum += s;
            end
            if (swCtrl[c].mono || swCtrl[c].right) begin
                rightSum += s;
            end
        end
        f.left  = clampSample(leftSum);
        f.right = clampSample(rightSum);
        return f;
    endfunction

    function automatic chanCtrl_t makeCtrl(input logic play, input logic loop,
                                           input logic mono, input logic right);
        chanCtrl_t c;
        c       = '0;
        c.play  = play;
        c.loop  = loop;
        c.mono  = mono;
        c.right = right;
        return c;
    endfunction

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkStereo(input string name, input stereo_t got, input stereo_t exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch o_sdata %s: got 0x%08h, expected 0x%08h",
                              name, got, exp));
        end
    endtask

    task automatic checkPlaying(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch o_playing: got 0x%02h, expected 0x%02h", got, exp));
        end
    endtask

    task automatic driveWrite(input regWrite_t w);
        i_reg   = w;
        i_regWr = 1'b1;
        @(posedge clk);
        #5;
        i_regWr = 1'b0;
    endtask

    task automatic setRange(input int ch, input int first, input int last);
        regWrite_t w;
        w.chanMask  = 8'(1 << ch);
        w.sel       = REG_START;
        w.data.addr = 24'(first);
        driveWrite(w);
        w.sel       = REG_END;
        w.data.addr = 24'(last);
        driveWrite(w);
        swStart[ch] = 10'(first);
        swEnd[ch]   = 10'(last);
    endtask

    task automatic writeCtrl(input logic [NUM_CH-1:0] mask, input chanCtrl_t c);
        regWrite_t w;
        w.chanMask  = mask;
        w.sel       = REG_CTRL;
        w.data.ctrl = c;
        driveWrite(w);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (mask[ch]) begin
                swCtrl[ch] = c;
                swAddr[ch] = swStart[ch];
            end
        end
    endtask

    task automatic popFrame(output stereo_t f);
        int waited;
        waited = 0;
        while (rxFrames.size() == 0) begin
            if (waited == WAIT_LIMIT) begin
                failRun("Timed out waiting for a decoded serial frame");
            end
            @(posedge clk);
            #5;
            waited++;
        end
        f = rxFrames.pop_front();
    endtask

    task automatic skipFrames(input int count);
        stereo_t f;
        for (int i = 0; i < count; i++) begin
            popFrame(f);
        end
    endtask

    // Mid-frame, so play writes land before the next sweep
    task automatic waitLrRise();
        int   waited;
        logic prevLr;
        waited = 0;
        prevLr = o_lrclk;
        while (!(o_lrclk && !prevLr)) begin
            if (waited == WAIT_LIMIT) begin
                failRun("Timed out waiting for word select to rise");
            end
            prevLr = o_lrclk;
            @(posedge clk);
            #5;
            waited++;
        end
    endtask

    task automatic stopAll();
        writeCtrl('1, makeCtrl(1'b0, 1'b0, 1'b0, 1'b0));
        skipFrames(4);
        rxFrames.delete();
    endtask

    task automatic compareFrames(input int numFrames, input string name);
        stereo_t expQ [$];
        stereo_t got;
        int      skipped;
        for (int i = 0; i < numFrames; i++) begin
            expQ.push_back(nextMixFrame());
        end
        while (expQ.size() > 0 && expQ[0] == '0) begin
            expQ.delete(0);  // Looks the same as idle output
        end
        if (expQ.size() == 0) begin
            failRun($sformatf("No nonzero frame expected for %s", name));
        end
        skipped = 0;
        popFrame(got);
        while (got == '0) begin
            if (skipped == 4) begin
                failRun($sformatf("No nonzero frame arrived for %s", name));
            end
            skipped++;
            popFrame(got);
        end
        foreach (expQ[i]) begin
            if (i > 0) begin
                popFrame(got);
            end
            checkStereo(name, got, expQ[i]);
        end
    endtask

    task automatic monoPlayback();
        stereo_t got;
        stopAll();
        setRange(0, 16, 24);
        waitLrRise();
        writeCtrl(8'h01, makeCtrl(1'b1, 1'b0, 1'b1, 1'b0));
        checkPlaying(o_playing, 8'h01);
        compareFrames(8, "mono frame");
        for (int i = 0; i < 2; i++) begin
            popFrame(got);
            checkStereo("silent frame", got, '0);
        end
        checkPlaying(o_playing, 8'h00);
    endtask

    task automatic panSplit();
        stopAll();
        setRange(1, 40, 46);
        setRange(2, 60, 65);
        waitLrRise();
        writeCtrl(8'h02, makeCtrl(1'b1, 1'b0, 1'b0, 1'b0));
        writeCtrl(8'h04, makeCtrl(1'b1, 1'b0, 1'b0, 1'b1));
        compareFrames(7, "panned frame");
    endtask

    task automatic saturationClamp();
        stopAll();
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                sampleMem[200 + 4 * k + j] = (j < 2) ? 16'(32767 - 7 * k - j)
                                                     : 16'(-32768 + 5 * k + j);
            end
            setRange(k, 200 + 4 * k, 204 + 4 * k);
        end
        waitLrRise();
        writeCtrl(8'h0F, makeCtrl(1'b1, 1'b0, 1'b1, 1'b0));
        compareFrames(5, "saturated frame");
    endtask

    task automatic loopAndStop();
        stereo_t got;
        stopAll();
        setRange(3, 80, 83);
        waitLrRise();
        writeCtrl(8'h08, makeCtrl(1'b1, 1'b1, 1'b1, 1'b0));
        compareFrames(10, "looping frame");
        checkPlaying(o_playing, 8'h08);
        writeCtrl(8'h08, makeCtrl(1'b0, 1'b1, 1'b1, 1'b0));
        checkPlaying(o_playing, 8'h00);
        rxFrames.delete();
        skipFrames(3);
        for (int i = 0; i < 2; i++) begin
            popFrame(got);
            checkStereo("silent frame", got, '0);
        end
    endtask

    task automatic randomMix();
        logic [31:0] r;
        int          first;
        chanCtrl_t   ctrls [NUM_CH];
        stopAll();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            r     = nextRandom();
            first = int'(r[15:0] % 1000);
            setRange(ch, first, first + 2 + int'(r[18:16]));
            ctrls[ch] = makeCtrl(1'b1, r[20], r[21], r[22]);
        end
        waitLrRise();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            writeCtrl(8'(1 << ch), ctrls[ch]);
        end
        compareFrames(16, "random mix frame");
    endtask

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        i_rstN    = 1'b0;
        i_regWr   = 1'b0;
        i_reg     = '0;
        i_memData = '0;
        for (int i = 0; i < 1024; i++) begin
            r            = nextRandom();
            sampleMem[i] = r[15:0];
        end
        repeat (4) @(posedge clk);
        #5;
        i_rstN = 1'b1;
        checkPlaying(o_playing, 8'h00);  // All voices idle out of reset
        monoPlayback();
        panSplit();
        saturationClamp();
        loopAndStop();
        randomMix();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* tb_audioSystem_assert.sv */
`timescale 1ns/1ns

module audioSystemAssert (
    input logic clk,
    input logic i_rstN,
    input logic i_memReq,
    input logic i_bclk,
    input logic i_lrclk,
    input logic i_sdata
);

    // Serial lines only move with a falling bit clock
    serialOnFall: assert property (@(posedge clk) disable iff (!i_rstN)
        ($changed(i_lrclk) || $changed(i_sdata)) |-> $fell(i_bclk))
        else $error("o_lrclk or o_sdata changed outside a falling bit clock edge");

    quietInReset: assert property (@(negedge clk) !i_rstN |-> !i_memReq)
        else $error("o_memReq high while in reset");

    singleReq: assert property (@(posedge clk) disable iff (!i_rstN)
        i_memReq |=> !i_memReq)
        else $error("o_memReq held high for more than one cycle");

endmodule

bind audioSystem audioSystemAssert u_audioSystemAssert (
    .clk      (clk),
    .i_rstN   (i_rstN),
    .i_memReq (o_memReq),
    .i_bclk   (o_bclk),
    .i_lrclk  (o_lrclk),
    .i_sdata  (o_sdata)
);
